// ==== common/mem_pkg.sv ====
package mem_pkg;

    // Core data path
    localparam int XLEN = 32;
    localparam int LINE_BITS = 64;      // Cache line and memory bus width

    // Direct-mapped cache geometry, index from addr[5:3]
    localparam int CACHE_LINES = 8;
    localparam int INDEX_BITS = 3;
    localparam int TAG_BITS = XLEN - INDEX_BITS - 3;

    // Main memory, 2 KB of doublewords
    localparam int MEM_DEPTH = 256;
    localparam int MEM_ADDR_BITS = $clog2(MEM_DEPTH);
    localparam int MEM_LATENCY = 2;     // Load accept to data strobe
    localparam int LAT_BITS = $clog2(MEM_LATENCY + 1);

    // Load/store request queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_BITS = $clog2(QUEUE_DEPTH);

    // Access size, same encoding as funct3 of loads
    localparam logic [2:0] SIZE_B = 3'b000;
    localparam logic [2:0] SIZE_H = 3'b001;
    localparam logic [2:0] SIZE_W = 3'b010;
    localparam logic [2:0] SIZE_BU = 3'b100;
    localparam logic [2:0] SIZE_HU = 3'b101;

    // Memory bus command
    typedef enum logic [1:0] {
        BUS_NONE = 2'b00,
        BUS_LOAD = 2'b01,
        BUS_STORE = 2'b10
    } bus_cmd_t;

endpackage

// ==== dcache/dcache.sv ====
`timescale 1ns/1ps

module dcache (
    input  logic                              clk,
    input  logic                              rst,

    // Load/store side, request held until cache_valid
    input  logic                              cache_read,
    input  logic                              cache_write,
    input  logic [mem_pkg::XLEN-1:0]          cache_addr,
    input  logic [mem_pkg::XLEN-1:0]          cache_wdata,
    input  logic [2:0]                        cache_size,
    output logic                              cache_valid,
    output logic [mem_pkg::XLEN-1:0]          cache_rdata,

    // Memory side
    output mem_pkg::bus_cmd_t                 mem_cmd,
    output logic [mem_pkg::XLEN-1:0]          mem_addr,
    output logic [mem_pkg::LINE_BITS-1:0]     mem_wdata,
    input  logic                              mem_rvalid,
    input  logic [mem_pkg::LINE_BITS-1:0]     mem_rdata
);

    // Line storage
    logic                               line_valid [mem_pkg::CACHE_LINES];
    logic [mem_pkg::TAG_BITS-1:0]       line_tag   [mem_pkg::CACHE_LINES];
    logic [mem_pkg::LINE_BITS-1:0]      line_data  [mem_pkg::CACHE_LINES];

    logic [mem_pkg::INDEX_BITS-1:0]     index;
    logic [mem_pkg::TAG_BITS-1:0]       tag;
    logic                               access;
    logic                               hit;
    logic                               fill;
    logic                               store_hit;
    logic [mem_pkg::LINE_BITS-1:0]      cur_line;
    logic [mem_pkg::LINE_BITS-1:0]      merged;
    logic [mem_pkg::XLEN-1:0]           word;
    logic [7:0]                         sel_byte;
    logic [15:0]                        sel_half;

    assign index = cache_addr[mem_pkg::INDEX_BITS+2:3];
    assign tag = cache_addr[mem_pkg::XLEN-1:mem_pkg::INDEX_BITS+3];

    assign access = cache_read || cache_write;
    assign cur_line = line_data[index];
    assign hit = line_valid[index] && (line_tag[index] == tag);
    assign fill = access && !hit && mem_rvalid;     // Install on the data strobe
    assign store_hit = cache_write && hit;

    assign cache_valid = access && hit;

    // Store word merged into the current line
    always_comb begin
        if (cache_addr[2]) begin
            merged = {cache_wdata, cur_line[31:0]};
        end else begin
            merged = {cur_line[63:32], cache_wdata};
        end
    end

    // Valid bits are the only state cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_pkg::CACHE_LINES; i++) begin
                line_valid[i] <= 1'b0;
            end
        end else if (fill) begin
            line_valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            line_tag[index] <= tag;
            line_data[index] <= mem_rdata;
        end else if (store_hit) begin
            line_data[index] <= merged;     // Write-through, memory gets the same line
        end
    end

    // Memory command
    always_comb begin
        mem_cmd = mem_pkg::BUS_NONE;
        if (access) begin
            if (hit) begin
                if (cache_write) begin
                    mem_cmd = mem_pkg::BUS_STORE;
                end
            end else if (!mem_rvalid) begin
                mem_cmd = mem_pkg::BUS_LOAD;    // Held until the fill cycle
            end
        end
    end

    assign mem_addr = {cache_addr[mem_pkg::XLEN-1:3], 3'b000};
    assign mem_wdata = merged;

    // Load extraction
    assign word = cache_addr[2] ? cur_line[63:32] : cur_line[31:0];
    assign sel_half = cache_addr[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (cache_addr[1:0])
            2'd0: sel_byte = word[7:0];
            2'd1: sel_byte = word[15:8];
            2'd2: sel_byte = word[23:16];
            default: sel_byte = word[31:24];
        endcase
    end

    always_comb begin
        case (cache_size)
            mem_pkg::SIZE_B: begin
                cache_rdata = {{(mem_pkg::XLEN-8){sel_byte[7]}}, sel_byte};
            end
            mem_pkg::SIZE_H: begin
                cache_rdata = {{(mem_pkg::XLEN-16){sel_half[15]}}, sel_half};
            end
            mem_pkg::SIZE_BU: begin
                cache_rdata = {{(mem_pkg::XLEN-8){1'b0}}, sel_byte};
            end
            mem_pkg::SIZE_HU: begin
                cache_rdata = {{(mem_pkg::XLEN-16){1'b0}}, sel_half};
            end
            mem_pkg::SIZE_W: begin
                cache_rdata = word;
            end
            default: begin
                cache_rdata = word;     // Unused codes read as a word
            end
        endcase
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dcache_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_dcache_top -f verilog.f -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

# Pass only when the testbench printed its pass line
echo "$output" | grep -qx "ALL CHECKS PASSED"

// ==== tests/tb_dcache_top.sv ====
`timescale 1ns/1ps

module tb_dcache_top;

    localparam int CLK_PERIOD = 20;
    localparam int MEM_BYTES = mem_pkg::MEM_DEPTH * 8;
    localparam int TOTAL_REQS = 380;    // Requests of all tests, rounded up
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * (mem_pkg::MEM_LATENCY + 4) + 200;

    logic                       clk;
    logic                       rst;
    logic                       req_valid;
    logic                       req_write;
    logic [mem_pkg::XLEN-1:0]   req_addr;
    logic [mem_pkg::XLEN-1:0]   req_wdata;
    logic [2:0]                 req_size;
    logic                       queue_full;
    logic                       resp_valid;
    logic                       resp_write;
    logic [mem_pkg::XLEN-1:0]   resp_addr;
    logic [mem_pkg::XLEN-1:0]   resp_rdata;

    // Byte-wide reference memory, little endian
    logic [7:0]     model_mem [MEM_BYTES];

    // Expected responses in issue order
    logic           exp_write [$];
    logic [31:0]    exp_addr [$];
    logic [31:0]    exp_rdata [$];
    logic           e_write;
    logic [31:0]    e_addr;
    logic [31:0]    e_rdata;
    logic           exp_full;

    integer seed;
    int cycle_cnt = 0;
    int issue_cycle = 0;
    int resp_cycle = 0;
    int errors = 0;
    int resp_cnt = 0;
    int sent_cnt = 0;
    int test_errors = 0;
    int test_resps = 0;
    int queued = 0;

    dcache_top i_dcache_top (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_size, .queue_full,
        .resp_valid, .resp_write, .resp_addr, .resp_rdata
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, no progress after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // Response monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (resp_valid) begin
                resp_cnt++;
                resp_cycle = cycle_cnt;
                if (exp_write.size() == 0) begin
                    errors++;
                    $display("Response for address %h arrived with nothing outstanding", resp_addr);
                end else begin
                    e_write = exp_write.pop_front();
                    e_addr = exp_addr.pop_front();
                    e_rdata = exp_rdata.pop_front();
                    if (resp_write !== e_write) begin
                        errors++;
                        $display("[FAIL] resp_write expected %h, got %h", e_write, resp_write);
                    end
                    if (resp_addr !== e_addr) begin
                        errors++;
                        $display("[FAIL] resp_addr expected %h, got %h", e_addr, resp_addr);
                    end
                    if (!e_write && resp_rdata !== e_rdata) begin
                        errors++;
                        $display("[FAIL] resp_rdata at %h expected %h, got %h",
                                 e_addr, e_rdata, resp_rdata);
                    end
                end
            end
            // Entries inside the queue, the strobe of this cycle is not pushed yet
            queued = exp_write.size() - (req_valid ? 1 : 0);
            exp_full = (queued == mem_pkg::QUEUE_DEPTH);
            if (queue_full !== exp_full) begin
                errors++;
                $display("[FAIL] queue_full expected %h, got %h", exp_full, queue_full);
            end
        end
    end

    function automatic logic [31:0] model_load(input logic [31:0] addr, input logic [2:0] size);
        logic [10:0]    a;
        logic [7:0]     b;
        logic [15:0]    h;
        logic [31:0]    w;
        a = addr[10:0];
        b = model_mem[a];
        h = {model_mem[a + 11'd1], b};
        w = {model_mem[a + 11'd3], model_mem[a + 11'd2], model_mem[a + 11'd1], b};
        case (size)
            mem_pkg::SIZE_B: model_load = {{24{b[7]}}, b};
            mem_pkg::SIZE_H: model_load = {{16{h[15]}}, h};
            mem_pkg::SIZE_BU: model_load = {24'h0, b};
            mem_pkg::SIZE_HU: model_load = {16'h0, h};
            default: model_load = w;
        endcase
    endfunction

    task automatic model_store(input logic [31:0] addr, input logic [31:0] wdata);
        logic [10:0] a;
        a = {addr[10:2], 2'b00};    // Word stores only
        model_mem[a] = wdata[7:0];
        model_mem[a + 11'd1] = wdata[15:8];
        model_mem[a + 11'd2] = wdata[23:16];
        model_mem[a + 11'd3] = wdata[31:24];
    endtask

    // One-cycle strobe, entered and left 2 ns after a rising edge
    task automatic send(input logic write, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [2:0] size);
        while (queue_full) begin
            @(posedge clk);
            #2;
        end
        req_valid = 1'b1;
        req_write = write;
        req_addr = addr;
        req_wdata = wdata;
        req_size = size;
        exp_write.push_back(write);
        exp_addr.push_back(addr);
        if (write) begin
            model_store(addr, wdata);
            exp_rdata.push_back(32'h0);
        end else begin
            exp_rdata.push_back(model_load(addr, size));
        end
        issue_cycle = cycle_cnt;
        sent_cnt++;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_write.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic finish_test(input string name);
        wait_idle();
        if (resp_cnt != sent_cnt) begin
            errors++;
            $display("Counts differ, %0d requests sent and %0d answered", sent_cnt, resp_cnt);
        end
        $display("%s: %0d responses, %0d errors", name, resp_cnt - test_resps,
                 errors - test_errors);
        test_resps = resp_cnt;
        test_errors = errors;
    endtask

    initial begin
        logic [31:0]    r;
        logic [31:0]    addr;
        logic [31:0]    base;
        logic [31:0]    other;
        logic [31:0]    wdata;
        int             first;
        int             second;

        seed = 32'h4a6c_e23f;
        rst = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = 32'h0;
        req_wdata = 32'h0;
        req_size = mem_pkg::SIZE_W;
        model_mem = '{default: 8'h00};
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // Reset loads, one per line index so every first access misses
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            addr = {22'h0, r[9:6], i[2:0], r[2], 2'b00};
            send(1'b0, addr, 32'h0, mem_pkg::SIZE_W);
            wait_idle();
            first = resp_cycle - issue_cycle;
            send(1'b0, addr, 32'h0, mem_pkg::SIZE_W);
            wait_idle();
            second = resp_cycle - issue_cycle;
            if (first <= 2) begin
                errors++;
                $display("First load of %h answered in %0d cycles, no miss seen", addr, first);
            end
            if (second != 2) begin
                errors++;
                $display("Load hit at %h took %0d cycles instead of 2", addr, second);
            end
        end
        finish_test("reset loads");

        // Every size at every offset, both sign polarities
        r = $random(seed);
        addr = {22'h0, r[9:2], 2'b00};
        wdata = $random(seed);
        for (int p = 0; p < 2; p++) begin
            send(1'b1, addr, wdata, mem_pkg::SIZE_W);
            send(1'b0, addr, 32'h0, mem_pkg::SIZE_W);
            for (int k = 0; k < 4; k++) begin
                send(1'b0, {addr[31:2], k[1:0]}, 32'h0, mem_pkg::SIZE_B);
                send(1'b0, {addr[31:2], k[1:0]}, 32'h0, mem_pkg::SIZE_BU);
            end
            for (int k = 0; k < 2; k++) begin
                send(1'b0, {addr[31:2], k[0], 1'b0}, 32'h0, mem_pkg::SIZE_H);
                send(1'b0, {addr[31:2], k[0], 1'b0}, 32'h0, mem_pkg::SIZE_HU);
            end
            wdata = ~wdata;
        end
        finish_test("load sizes");

        // Store misses in the untouched 0x600 region
        r = $random(seed);
        base = {21'h0, 2'b11, r[5:0], 3'b000};
        wdata = $random(seed);
        send(1'b1, {base[31:3], 3'b100}, wdata, mem_pkg::SIZE_W);
        send(1'b0, {base[31:11], 2'b10, base[8:0]}, 32'h0, mem_pkg::SIZE_W);  // Evicts the line
        wdata = $random(seed);
        send(1'b1, base, wdata, mem_pkg::SIZE_W);
        send(1'b0, base, 32'h0, mem_pkg::SIZE_W);
        send(1'b0, {base[31:3], 3'b100}, 32'h0, mem_pkg::SIZE_W);
        finish_test("store miss merge");

        // Same index, two tags, accessed in turn
        r = $random(seed);
        base = {23'h0, 3'b001, r[2:0], 3'b000};
        other = base | 32'h200;
        for (int i = 0; i < 8; i++) begin
            addr = i[0] ? other : base;
            wdata = $random(seed);
            send(1'b1, {addr[31:3], i[1], 2'b00}, wdata, mem_pkg::SIZE_W);
            send(1'b0, {base[31:3], i[2], 2'b00}, 32'h0, mem_pkg::SIZE_W);
            send(1'b0, {other[31:3], i[2], 2'b00}, 32'h0, mem_pkg::SIZE_W);
        end
        finish_test("index conflict");

        // Back-to-back random traffic over 16 doublewords, four tags per index
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            addr = {21'h0, r[1:0], 3'b000, 1'b0, r[3:2], r[4], r[6:5]};
            wdata = $random(seed);
            if (r[7]) begin
                send(1'b1, {addr[31:2], 2'b00}, wdata, mem_pkg::SIZE_W);
            end else begin
                case (r[10:8])
                    3'd0: send(1'b0, {addr[31:2], 2'b00}, 32'h0, mem_pkg::SIZE_W);
                    3'd1, 3'd2: send(1'b0, {addr[31:1], 1'b0}, 32'h0, mem_pkg::SIZE_H);
                    3'd3: send(1'b0, {addr[31:1], 1'b0}, 32'h0, mem_pkg::SIZE_HU);
                    3'd4, 3'd5: send(1'b0, addr, 32'h0, mem_pkg::SIZE_B);
                    default: send(1'b0, addr, 32'h0, mem_pkg::SIZE_BU);
                endcase
            end
        end
        finish_test("random burst");

        repeat (5) @(posedge clk);  // Room for a stray response
        $display("%0d requests, %0d responses, %0d errors", sent_cnt, resp_cnt, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
common/mem_pkg.sv
dcache/dcache.sv
verilog/ls_port.sv
verilog/main_mem.sv
verilog/dcache_top.sv
tests/tb_dcache_top.sv

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic [mem_pkg::XLEN-1:0]      req_addr,
    input  logic [mem_pkg::XLEN-1:0]      req_wdata,
    input  logic [2:0]                    req_size,
    output logic                          queue_full,
    output logic                          resp_valid,
    output logic                          resp_write,
    output logic [mem_pkg::XLEN-1:0]      resp_addr,
    output logic [mem_pkg::XLEN-1:0]      resp_rdata
);

    // Queue to cache
    logic                             cache_read;
    logic                             cache_write;
    logic [mem_pkg::XLEN-1:0]         cache_addr;
    logic [mem_pkg::XLEN-1:0]         cache_wdata;
    logic [2:0]                       cache_size;
    logic                             cache_valid;
    logic [mem_pkg::XLEN-1:0]         cache_rdata;

    // Cache to memory
    mem_pkg::bus_cmd_t                mem_cmd;
    logic [mem_pkg::XLEN-1:0]         mem_addr;
    logic [mem_pkg::LINE_BITS-1:0]    mem_wdata;
    logic                             mem_rvalid;
    logic [mem_pkg::LINE_BITS-1:0]    mem_rdata;

    ls_port i_ls_port (
        .clk, .rst,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_size, .queue_full,
        .cache_read, .cache_write, .cache_addr, .cache_wdata, .cache_size,
        .cache_valid, .cache_rdata,
        .resp_valid, .resp_write, .resp_addr, .resp_rdata
    );

    dcache i_dcache (
        .clk, .rst,
        .cache_read, .cache_write, .cache_addr, .cache_wdata, .cache_size,
        .cache_valid, .cache_rdata,
        .mem_cmd, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata
    );

    main_mem i_main_mem (
        .clk, .rst,
        .mem_cmd, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata
    );

endmodule

// ==== verilog/ls_port.sv ====
`timescale 1ns/1ps

module ls_port (
    input  logic                          clk,
    input  logic                          rst,

    // Strobed requests
    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic [mem_pkg::XLEN-1:0]      req_addr,
    input  logic [mem_pkg::XLEN-1:0]      req_wdata,
    input  logic [2:0]                    req_size,
    output logic                          queue_full,

    // Cache request, held for the queue head
    output logic                          cache_read,
    output logic                          cache_write,
    output logic [mem_pkg::XLEN-1:0]      cache_addr,
    output logic [mem_pkg::XLEN-1:0]      cache_wdata,
    output logic [2:0]                    cache_size,
    input  logic                          cache_valid,
    input  logic [mem_pkg::XLEN-1:0]      cache_rdata,

    // Strobed responses
    output logic                          resp_valid,
    output logic                          resp_write,
    output logic [mem_pkg::XLEN-1:0]      resp_addr,
    output logic [mem_pkg::XLEN-1:0]      resp_rdata
);

    logic                         q_write [mem_pkg::QUEUE_DEPTH];
    logic [mem_pkg::XLEN-1:0]     q_addr  [mem_pkg::QUEUE_DEPTH];
    logic [mem_pkg::XLEN-1:0]     q_wdata [mem_pkg::QUEUE_DEPTH];
    logic [2:0]                   q_size  [mem_pkg::QUEUE_DEPTH];

    logic [mem_pkg::QPTR_BITS-1:0]  rd_ptr;
    logic [mem_pkg::QPTR_BITS-1:0]  wr_ptr;
    logic [mem_pkg::QPTR_BITS:0]    count;
    logic                           empty;
    logic                           push;
    logic                           pop;

    assign empty = (count == '0);
    assign queue_full = (count == mem_pkg::QUEUE_DEPTH);
    assign push = req_valid && !queue_full;     // Strobe while full is lost
    assign pop = cache_valid && !empty;

    // Head entry as a level
    assign cache_read = !empty && !q_write[rd_ptr];
    assign cache_write = !empty && q_write[rd_ptr];
    assign cache_addr = q_addr[rd_ptr];
    assign cache_wdata = q_wdata[rd_ptr];
    assign cache_size = q_size[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= pop;
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_write[wr_ptr] <= req_write;
            q_addr[wr_ptr] <= req_addr;
            q_wdata[wr_ptr] <= req_wdata;
            q_size[wr_ptr] <= req_size;
        end
        if (pop) begin
            resp_write <= q_write[rd_ptr];
            resp_addr <= q_addr[rd_ptr];
            resp_rdata <= cache_rdata;
        end
    end

endmodule

// ==== verilog/main_mem.sv ====
`timescale 1ns/1ps

module main_mem (
    input  logic                              clk,
    input  logic                              rst,
    input  mem_pkg::bus_cmd_t                 mem_cmd,
    input  logic [mem_pkg::XLEN-1:0]          mem_addr,
    input  logic [mem_pkg::LINE_BITS-1:0]     mem_wdata,
    output logic                              mem_rvalid,
    output logic [mem_pkg::LINE_BITS-1:0]     mem_rdata
);

    logic [mem_pkg::LINE_BITS-1:0]      mem [mem_pkg::MEM_DEPTH];

    logic [mem_pkg::MEM_ADDR_BITS-1:0]  idx;
    logic [mem_pkg::MEM_ADDR_BITS-1:0]  load_idx;   // Latched on acceptance
    logic                               pending;
    logic [mem_pkg::LAT_BITS-1:0]       lat_cnt;
    logic                               accept;
    logic                               fire;

    assign idx = mem_addr[mem_pkg::MEM_ADDR_BITS+2:3];
    assign accept = (mem_cmd == mem_pkg::BUS_LOAD) && !pending;    // Repeats ignored
    assign fire = pending && (lat_cnt == mem_pkg::LAT_BITS'(mem_pkg::MEM_LATENCY - 1));

    // Storage, stores land at once
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_cmd == mem_pkg::BUS_STORE) begin
            mem[idx] <= mem_wdata;
        end
    end

    // Load latency
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            lat_cnt <= '0;
            mem_rvalid <= 1'b0;
        end else begin
            mem_rvalid <= fire;
            if (accept) begin
                pending <= 1'b1;
                lat_cnt <= mem_pkg::LAT_BITS'(1);
            end else if (fire) begin
                pending <= 1'b0;
            end else if (pending) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) load_idx <= idx;
        if (fire) mem_rdata <= mem[load_idx];
    end

endmodule
